// File: source/rv_hazard_pkg.sv
package rv_hazard_pkg;

  // Register index width, shared by the integer and FP files
  localparam int REG_W = 5;
  // Width of the per-instruction stall counter
  localparam int STALL_CNT_W = 4;
  // Number of FP source operands (fmadd and friends use three)
  localparam int FP_SRC_N = 3;

  typedef logic [REG_W-1:0] reg_idx_t;
  typedef logic [STALL_CNT_W-1:0] stall_cnt_t;

  // x0 is hardwired, never a real producer
  localparam reg_idx_t REG_ZERO = '0;

  // Decoded instruction as seen in ID
  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     rs1_used;
    logic     rs2_used;
    reg_idx_t fp_rs1;
    reg_idx_t fp_rs2;
    reg_idx_t fp_rs3;
    logic     fp_rs1_used;
    logic     fp_rs2_used;
    logic     fp_rs3_used;
    reg_idx_t rd;
    logic     rd_write;
    logic     fp_rd_write;
    logic     is_load;
  } id_instr_t;

  // Destination record of one in-flight instruction
  typedef struct packed {
    reg_idx_t rd;
    logic     rd_write;
    logic     fp_rd_write;
    logic     is_load;
  } stage_rec_t;

  // All flags clear, so it never matches a source
  localparam stage_rec_t BUBBLE_REC = '0;

  typedef struct packed {
    stage_rec_t ex;
    stage_rec_t mem;
    stage_rec_t wb;
  } stage_recs_t;

  typedef enum logic [1:0] {
    IDLE,
    HELD,
    ISSUE
  } stall_state_t;

endpackage

// File: source/rv_dest_pipe.sv
`timescale 1ns/10ps

// Destination records for EX, MEM and WB
//
// Advances on every clock. Anything that did not issue from ID
// (stall, flush or no valid instruction) enters EX as a bubble.
module rv_dest_pipe
  import rv_hazard_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        issue,
  input  id_instr_t   instr,
  output stage_recs_t recs
);

  stage_rec_t ex_next;
  stage_rec_t ex_q;
  stage_rec_t mem_q;
  stage_rec_t wb_q;

  // Build the EX record from the issuing instruction
  always_comb begin
    ex_next = BUBBLE_REC;
    if (issue) begin
      ex_next.rd          = instr.rd;
      // A write to x0 is discarded, so it cannot be a producer
      ex_next.rd_write    = instr.rd_write && (instr.rd != REG_ZERO);
      ex_next.fp_rd_write = instr.fp_rd_write;
      ex_next.is_load     = instr.is_load;
    end
  end

  // Shift register, one record per stage
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_q  <= BUBBLE_REC;
      mem_q <= BUBBLE_REC;
      wb_q  <= BUBBLE_REC;
    end else begin
      ex_q  <= ex_next;
      // Older records move on regardless of ID stalls
      mem_q <= ex_q;
      wb_q  <= mem_q;
    end
  end

  // Bundle for both checkers
  always_comb begin
    recs.ex  = ex_q;
    recs.mem = mem_q;
    recs.wb  = wb_q;
  end

endmodule

// File: source/rv_int_hazard.sv
`timescale 1ns/10ps

// Integer load-use check
//
// ALU results reach ID users through the forwarding network, and
// the register file writes before it reads, so only a load still
// in EX has no value yet. MEM and WB need no check here.
module rv_int_hazard
  import rv_hazard_pkg::*;
(
  input  id_instr_t   instr,
  input  stage_recs_t recs,
  output logic        int_stall_req
);

  logic ex_load;
  logic rs1_hit;
  logic rs2_hit;

  // EX holds a load that will write an integer register
  assign ex_load = recs.ex.rd_write && recs.ex.is_load;

  always_comb begin
    rs1_hit = 1'b0;
    rs2_hit = 1'b0;

    if (ex_load) begin
      // x0 reads as zero, never waits on a producer
      rs1_hit = instr.rs1_used &&
                (instr.rs1 != REG_ZERO) &&
                (instr.rs1 == recs.ex.rd);
      rs2_hit = instr.rs2_used &&
                (instr.rs2 != REG_ZERO) &&
                (instr.rs2 == recs.ex.rd);
    end
  end

  // Either source matching is enough to hold ID one cycle
  assign int_stall_req = rs1_hit || rs2_hit;

endmodule

// File: source/rv_fp_hazard.sv
`timescale 1ns/10ps

// FP read-after-write check
//
// FP results are not forwarded, so a user must wait until the
// producer reaches WB. The FP register file writes before it
// reads, which leaves only EX and MEM to compare against.
//
// Integer <-> FP moves use integer rd/rs fields and are covered
// by the integer checker.
module rv_fp_hazard
  import rv_hazard_pkg::*;
(
  input  id_instr_t   instr,
  input  stage_recs_t recs,
  output logic        fp_stall_req
);

  reg_idx_t            fp_src [FP_SRC_N];
  logic [FP_SRC_N-1:0] fp_used;
  logic [FP_SRC_N-1:0] ex_hit;
  logic [FP_SRC_N-1:0] mem_hit;
  logic                ex_hazard;
  logic                mem_hazard;

  // Source operands as an indexable list
  assign fp_src[0] = instr.fp_rs1;
  assign fp_src[1] = instr.fp_rs2;
  assign fp_src[2] = instr.fp_rs3;

  assign fp_used = {instr.fp_rs3_used, instr.fp_rs2_used, instr.fp_rs1_used};

  // Per-source match against EX
  always_comb begin
    ex_hit = '0;
    if (recs.ex.fp_rd_write) begin
      for (int i = 0; i < FP_SRC_N; i++) begin
        ex_hit[i] = fp_used[i] && (fp_src[i] == recs.ex.rd);
      end
    end
  end

  // Per-source match against MEM
  always_comb begin
    mem_hit = '0;
    if (recs.mem.fp_rd_write) begin
      for (int i = 0; i < FP_SRC_N; i++) begin
        mem_hit[i] = fp_used[i] && (fp_src[i] == recs.mem.rd);
      end
    end
  end

  assign ex_hazard  = |ex_hit;
  assign mem_hazard = |mem_hit;

  // f0 is a real register, unlike x0, so no zero exclusion
  assign fp_stall_req = ex_hazard || mem_hazard;

endmodule

// File: source/rv_stall_ctrl.sv
`timescale 1ns/10ps

// Stall combine and issue control
//
// A flush removes the ID instruction outright, so it masks any
// stall and blocks issue in the same cycle.
module rv_stall_ctrl
  import rv_hazard_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       instr_valid,
  input  logic       control_flush,
  input  logic       int_stall_req,
  input  logic       fp_stall_req,
  output logic       stall_id,
  output logic       issue,
  output stall_cnt_t issue_stalls
);

  stall_state_t state;
  stall_state_t state_next;
  stall_cnt_t   held_cnt;
  stall_cnt_t   cnt_next;
  logic         hazard;
  logic         live;

  assign hazard = int_stall_req || fp_stall_req;
  // Instruction present and not being killed
  assign live   = instr_valid && !control_flush;

  assign stall_id = live && hazard;
  assign issue    = live && !hazard;

  // Next state and held-cycle count
  always_comb begin
    state_next = IDLE;
    cnt_next   = '0;
    if (stall_id) begin
      state_next = HELD;
      // First held cycle restarts the count
      if (state != HELD) begin
        cnt_next = stall_cnt_t'(1);
      end else if (held_cnt != '1) begin
        cnt_next = held_cnt + 1'b1;
      end else begin
        cnt_next = held_cnt;
      end
    end else if (issue) begin
      state_next = ISSUE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      held_cnt <= '0;
    end else begin
      state    <= state_next;
      held_cnt <= cnt_next;
    end
  end

  // Count only means something for an instruction leaving HELD
  assign issue_stalls = (issue && (state == HELD)) ? held_cnt : '0;

endmodule

// File: source/rv_hazard_top.sv
`timescale 1ns/10ps

// ID-stage hazard detection
//
// Two checkers look at the ID instruction against the in-flight
// destination records and the controller turns their requests
// into stall_id / issue.
module rv_hazard_top
  import rv_hazard_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       instr_valid,
  input  id_instr_t  instr,
  input  logic       control_flush,
  output logic       stall_id,
  output logic       issue,
  output stall_cnt_t issue_stalls
);

  stage_recs_t recs;
  logic        int_stall_req;
  logic        fp_stall_req;

  // EX/MEM/WB destination tracking, fed by issue
  rv_dest_pipe u_dest_pipe (
    .clk   (clk),
    .rst   (rst),
    .issue (issue),
    .instr (instr),
    .recs  (recs)
  );

  // Load-use on integer sources
  rv_int_hazard u_int_hazard (
    .instr         (instr),
    .recs          (recs),
    .int_stall_req (int_stall_req)
  );

  // RAW on FP sources, no forwarding
  rv_fp_hazard u_fp_hazard (
    .instr        (instr),
    .recs         (recs),
    .fp_stall_req (fp_stall_req)
  );

  rv_stall_ctrl u_stall_ctrl (
    .clk           (clk),
    .rst           (rst),
    .instr_valid   (instr_valid),
    .control_flush (control_flush),
    .int_stall_req (int_stall_req),
    .fp_stall_req  (fp_stall_req),
    .stall_id      (stall_id),
    .issue         (issue),
    .issue_stalls  (issue_stalls)
  );

endmodule

// File: testbench/tb_clkgen.sv
`timescale 1ns/10ps

// Free-running testbench clock, 8 ns period
module tb_clkgen (
  output logic clk
);

  // Starts low, so the first rising edge comes at 4 ns
  initial begin
    clk = 1'b0;
  end

  // Half period of 4 ns
  always begin
    #4;
    clk = ~clk;
  end

endmodule

// File: testbench/rv_hazard_asserts.sv
`timescale 1ns/10ps

// Output protocol checks for the hazard block
module rv_hazard_asserts (
  input logic clk,
  input logic rst,
  input logic control_flush,
  input logic stall_id,
  input logic issue
);

  // An instruction either waits in ID or leaves, never both
  a_issue_or_stall: assert property (
    @(posedge clk) disable iff (rst) !(issue && stall_id)
  ) else $error("issue and stall_id high in the same cycle");

  // Flushed instruction neither waits nor issues
  a_flush_quiet: assert property (
    @(posedge clk) disable iff (rst) control_flush |-> !(issue || stall_id)
  ) else $error("issue or stall_id high during control_flush");

  a_reset_quiet: assert property (
    @(posedge clk) rst |-> !(issue || stall_id)
  ) else $error("issue or stall_id high during reset");

endmodule

bind rv_hazard_top rv_hazard_asserts u_asserts (
  .clk           (clk),
  .rst           (rst),
  .control_flush (control_flush),
  .stall_id      (stall_id),
  .issue         (issue)
);

// File: testbench/tb_hazard.sv
`timescale 1ns/10ps

// Testbench for the ID-stage hazard detection block
module tb_hazard
  import rv_hazard_pkg::*;
();

  // Words per stimulus line and the size of the stimulus memory
  localparam int FIELDS = 11;
  localparam int MAX_LINES = 64;
  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 10;
  // Generous bound on stall plus issue cycles for one line
  localparam int CYCLES_PER_LINE = 8;

  logic       clk;
  logic       rst;
  logic       instr_valid;
  id_instr_t  instr;
  logic       control_flush;
  logic       stall_id;
  logic       issue;
  stall_cnt_t issue_stalls;

  logic [7:0] stim [MAX_LINES*FIELDS];
  int         n_lines;
  logic       lines_ready = 1'b0;

  tb_clkgen u_clkgen (
    .clk (clk)
  );

  rv_hazard_top dut (
    .clk           (clk),
    .rst           (rst),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .control_flush (control_flush),
    .stall_id      (stall_id),
    .issue         (issue),
    .issue_stalls  (issue_stalls)
  );

  task automatic stop_with_failure();
    $display("** FAIL **");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_val(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL @ %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  // Assemble one decoded instruction from the packed flag columns
  function automatic id_instr_t build_instr(input int base);
    id_instr_t ins;
    ins             = '0;
    ins.rs1         = reg_idx_t'(stim[base]);
    ins.rs2         = reg_idx_t'(stim[base+1]);
    ins.rs1_used    = stim[base+2][1];
    ins.rs2_used    = stim[base+2][0];
    ins.fp_rs1      = reg_idx_t'(stim[base+3]);
    ins.fp_rs2      = reg_idx_t'(stim[base+4]);
    ins.fp_rs3      = reg_idx_t'(stim[base+5]);
    ins.fp_rs1_used = stim[base+6][2];
    ins.fp_rs2_used = stim[base+6][1];
    ins.fp_rs3_used = stim[base+6][0];
    ins.rd          = reg_idx_t'(stim[base+7]);
    ins.rd_write    = stim[base+8][2];
    ins.fp_rd_write = stim[base+8][1];
    ins.is_load     = stim[base+8][0];
    return ins;
  endfunction

  initial begin : stimulus
    id_instr_t cur_instr;
    logic      cur_flush;
    int        cur_exp;
    int        held;
    bit        done;
    rst           = 1'b1;
    instr_valid   = 1'b0;
    instr         = '0;
    control_flush = 1'b0;
    $readmemh("testbench/hazard_stim.txt", stim);
    // Line list ends at the first rs1 column of ff
    n_lines = 0;
    while ((n_lines < MAX_LINES) && (stim[n_lines*FIELDS] !== 8'hff)) begin
      n_lines++;
    end
    if (n_lines == MAX_LINES) begin
      $display("Stimulus file has no end marker line");
      stop_with_failure();
    end
    lines_ready = 1'b1;

    // Nothing may issue or stall while reset is held
    repeat (RESET_CYCLES - 1) begin
      @(posedge clk);
      @(negedge clk);
      check_val("issue in reset", 32'(issue), 32'd0);
      check_val("stall_id in reset", 32'(stall_id), 32'd0);
    end
    @(posedge clk);
    rst <= 1'b0;

    for (int line = 0; line < n_lines; line++) begin
      cur_instr = build_instr(line * FIELDS);
      cur_flush = stim[line*FIELDS+9][0];
      cur_exp   = int'(stim[line*FIELDS+10]);
      instr         <= cur_instr;
      instr_valid   <= 1'b1;
      control_flush <= cur_flush;
      held = 0;
      done = 1'b0;
      // Same instruction stays on the bus while ID is stalled
      while (!done) begin
        @(negedge clk);
        if (cur_flush) begin
          check_val("issue on flush", 32'(issue), 32'd0);
          check_val("stall_id on flush", 32'(stall_id), 32'd0);
          done = 1'b1;
        end else if (issue) begin
          check_val("issue_stalls", 32'(issue_stalls), 32'(cur_exp));
          check_val("cycles held in ID", 32'(held), 32'(cur_exp));
          done = 1'b1;
        end else begin
          check_val("stall_id while held", 32'(stall_id), 32'd1);
          held++;
        end
        @(posedge clk);
      end
    end

    instr_valid   <= 1'b0;
    control_flush <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_val("issue with no instruction", 32'(issue), 32'd0);
    end
    $display("** PASS **");
    $finish;
  end

  // Run limit scales with the number of stimulus lines
  initial begin : watchdog
    int limit_ns;
    wait (lines_ready === 1'b1);
    limit_ns = (RESET_CYCLES + n_lines * CYCLES_PER_LINE) * CLK_PERIOD;
    #(limit_ns);
    $display("Timeout: the run did not finish within %0d ns", limit_ns);
    stop_with_failure();
  end

endmodule

// File: testbench/hazard_stim.txt
// rs1 rs2 ru fr1 fr2 fr3 fu rd wf fl exp, hex; ru={rs1_used,rs2_used}, fu={fp_rs1..3_used}
// wf={rd_write,fp_rd_write,is_load}, fl=flush, exp=stall cycles; rs1 of ff ends the list
02 03 3 00 00 00 0 01 4 0 0  // add  x1, x2, x3
05 06 3 00 00 00 0 04 4 0 0  // add  x4, x5, x6
01 04 3 00 00 00 0 07 4 0 0  // add  x7, x1, x4 after ALU producers
07 00 2 00 00 00 0 08 5 0 0  // lw   x8, (x7)
08 01 3 00 00 00 0 09 4 0 1  // add  x9, x8, x1 load-use
03 00 2 00 00 00 0 00 5 0 0  // lw   x0, (x3)
00 03 3 00 00 00 0 0b 4 0 0  // add  x11, x0, x3
03 00 2 00 00 00 0 0c 5 0 0  // lw   x12, (x3)
00 00 0 0c 0c 00 6 01 2 0 0  // fadd f1, f12, f12 after int load to x12
01 01 3 00 00 00 0 01 4 0 0  // add  x1, x1, x1 after FP write to f1
00 00 0 01 03 00 6 02 2 0 1  // fmul f2, f1, f3 one gap
00 00 0 04 05 02 7 03 2 0 2  // fmadd f3, f4, f5, f2 via rs3
00 00 0 07 03 00 6 06 2 0 2  // fsub f6, f7, f3 via rs2
00 00 0 06 00 00 6 07 2 0 2  // fadd f7, f6, f0 via rs1
00 00 0 07 00 00 4 08 2 1 0  // fadd f8, f7 flushed
00 00 0 07 07 00 6 09 2 0 1  // fadd f9, f7, f7 bubble in EX
03 00 2 00 00 00 0 0d 5 0 0  // lw   x13, (x3)
0d 00 2 00 00 00 0 0e 4 1 0  // add  x14, x13 flushed
0d 02 3 00 00 00 0 0f 4 0 0  // add  x15, x13, x2
03 00 2 00 00 00 0 0a 3 0 0  // flw  f10, (x3)
0a 00 2 00 00 00 0 0a 4 0 0  // addi x10, x10 after FP load to f10
00 00 0 0a 00 00 4 0b 2 0 1  // fadd f11, f10 producer in MEM
00 00 0 00 00 00 0 00 0 0 0  // nop
00 00 0 00 00 00 0 00 0 0 0  // nop
00 00 0 0b 00 00 4 0c 2 0 0  // fadd f12, f11 producer in WB
00 00 2 00 00 00 0 10 5 0 0  // lw   x16, (x0)
02 10 3 00 00 00 0 11 4 0 1  // add  x17, x2, x16 via rs2
00 00 0 00 00 00 0 00 0 0 0  // nop
ff ff ff ff ff ff ff ff ff ff ff  // end of list

// File: tb.f
source/rv_hazard_pkg.sv
source/rv_dest_pipe.sv
source/rv_int_hazard.sv
source/rv_fp_hazard.sv
source/rv_stall_ctrl.sv
source/rv_hazard_top.sv
testbench/tb_clkgen.sv
testbench/rv_hazard_asserts.sv
testbench/tb_hazard.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module tb_hazard -f tb.f \
    -o tb_hazard_sim &&
  ./obj_dir/tb_hazard_sim ||
  { echo "Simulation failed"; exit 1; }
